//--- hw/ciPkg.sv
package ciPkg;

  localparam int dataWidth     = 32;
  localparam int ciNumberWidth = 8;

  // Custom instruction numbers
  localparam logic [ciNumberWidth-1:0] swapId      = 8'd1;
  localparam logic [ciNumberWidth-1:0] delayId     = 8'd6;
  localparam logic [ciNumberWidth-1:0] profileId   = 8'd8;
  localparam logic [ciNumberWidth-1:0] grayscaleId = 8'd12;

  localparam int ticksPerMicrosecond = 10; // 100 ns system clock
  localparam int tickCountWidth      = $clog2(ticksPerMicrosecond);
  localparam int resetCountWidth     = 5;  // Top bit sets 16 cycles after lock

  localparam int profileCounterCount = 3;
  // Command fields in operand B of the profile instruction
  localparam int profileEnableLsb    = 0;
  localparam int profileDisableLsb   = 4;
  localparam int profileZeroLsb      = 8;

  // Luma weights summing to 256
  localparam logic [7:0] grayRedWeight   = 8'd54;
  localparam logic [7:0] grayGreenWeight = 8'd183;
  localparam logic [7:0] grayBlueWeight  = 8'd19;

  // Delay FSM encoding
  localparam logic [1:0] delayIdle     = 2'd0;
  localparam logic [1:0] delayWaiting  = 2'd1;
  localparam logic [1:0] delayFinished = 2'd2;

  typedef union packed {
    logic [dataWidth/8-1:0][7:0] bytes;
    struct packed {
      logic [15:0] unused;
      logic [4:0]  red;
      logic [5:0]  green;
      logic [4:0]  blue;
    } pixel;
  } ciOperand;

endpackage

//--- hw/ciBus.sv
`timescale 1ns/1ps

interface ciBus import ciPkg::*; ();

  logic                     ciStart; // Single cycle strobe
  logic [ciNumberWidth-1:0] ciN;
  ciOperand                 ciDataA;
  logic [dataWidth-1:0]     ciDataB;

  modport source (
    output ciStart, ciN, ciDataA, ciDataB
  );

  modport unit (
    input ciStart, ciN, ciDataA, ciDataB
  );

endinterface

//--- hw/resetSequencer.sv
`timescale 1ns/1ps

module resetSequencer import ciPkg::*; (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic reset,
  output logic peripheralResetN
);

  logic [resetCountWidth-1:0] s_resetCountReg;
  logic                       s_released;

  assign s_released = s_resetCountReg[resetCountWidth-1];

  // Count up after lock, then hold
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      s_resetCountReg <= '0;
    end else if (!s_released) begin
      s_resetCountReg <= s_resetCountReg + 1'b1;
    end
  end

  assign reset            = ~s_released; // Internal, active high
  assign peripheralResetN = s_released;

endmodule

//--- hw/microsecondTimer.sv
`timescale 1ns/1ps

module microsecondTimer import ciPkg::*; (
  input  logic s_systemClock,
  input  logic reset,
  input  logic restart,
  output logic tick
);

  logic [tickCountWidth-1:0] s_countReg;

  // High while the count holds its last value
  assign tick = (s_countReg == tickCountWidth'(ticksPerMicrosecond - 1));

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_countReg <= '0;
    end else if (restart || tick) begin
      s_countReg <= '0;
    end else begin
      s_countReg <= s_countReg + 1'b1;
    end
  end

endmodule

//--- hw/delayController.sv
`timescale 1ns/1ps

module delayController import ciPkg::*; (
  input  logic                 s_systemClock,
  input  logic                 reset,
  ciBus.unit                   ci,
  output logic                 done,
  output logic [dataWidth-1:0] result
);

  logic [1:0]           s_stateReg;
  logic [dataWidth-1:0] s_remainingReg; // Microseconds still to wait
  logic                 s_startDelay;
  logic                 s_tick;

  // Only accepted when idle
  assign s_startDelay = ci.ciStart && (ci.ciN == delayId) && (s_stateReg == delayIdle);

  microsecondTimer timer (
    .s_systemClock(s_systemClock),
    .reset(reset),
    .restart(s_startDelay),
    .tick(s_tick)
  );

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_stateReg     <= delayIdle;
      s_remainingReg <= '0;
    end else begin
      case (s_stateReg)
        delayIdle: begin
          if (s_startDelay) begin
            s_remainingReg <= ci.ciDataA;
            s_stateReg     <= (ci.ciDataA == '0) ? delayFinished : delayWaiting;
          end
        end
        delayWaiting: begin
          if (s_tick) begin
            s_remainingReg <= s_remainingReg - 1'b1;
            if (s_remainingReg == dataWidth'(1)) begin
              s_stateReg <= delayFinished;
            end
          end
        end
        delayFinished: s_stateReg <= delayIdle; // Done lasts one cycle
        default:       s_stateReg <= delayIdle;
      endcase
    end
  end

  assign done   = (s_stateReg == delayFinished);
  assign result = '0; // Blocking delay returns nothing

endmodule

//--- hw/dataConversionUnit.sv
`timescale 1ns/1ps

module dataConversionUnit import ciPkg::*; (
  ciBus.unit                   ci,
  output logic                 done,
  output logic [dataWidth-1:0] result
);

  logic       s_isSwap;
  logic       s_isGray;
  ciOperand   s_swapped;
  logic [7:0] s_redWide;
  logic [7:0] s_greenWide;
  logic [7:0] s_blueWide;
  logic [15:0] s_weightedSum;
  logic [7:0] s_grayValue;

  assign s_isSwap = ci.ciStart && (ci.ciN == swapId);
  assign s_isGray = ci.ciStart && (ci.ciN == grayscaleId);

  // Byte reversal
  always_comb begin
    for (int i = 0; i < dataWidth / 8; i++) begin
      s_swapped.bytes[i] = ci.ciDataA.bytes[dataWidth/8-1-i];
    end
  end

  // RGB565 widened to 8 bits per channel
  assign s_redWide   = {ci.ciDataA.pixel.red, 3'b000};
  assign s_greenWide = {ci.ciDataA.pixel.green, 2'b00};
  assign s_blueWide  = {ci.ciDataA.pixel.blue, 3'b000};

  assign s_weightedSum = grayRedWeight * 16'(s_redWide) +
                         grayGreenWeight * 16'(s_greenWide) +
                         grayBlueWeight * 16'(s_blueWide);
  assign s_grayValue   = s_weightedSum[15:8]; // Divide by 256

  always_comb begin
    if (s_isSwap) begin
      result = s_swapped;
    end else if (s_isGray) begin
      result = {{(dataWidth - 8){1'b0}}, s_grayValue};
    end else begin
      result = '0; // Not addressed
    end
  end

  assign done = s_isSwap || s_isGray;

endmodule

//--- hw/profileCounters.sv
`timescale 1ns/1ps

module profileCounters import ciPkg::*; (
  input  logic                 s_systemClock,
  input  logic                 reset,
  input  logic                 cpuStalled,
  input  logic                 busIdle,
  ciBus.unit                   ci,
  output logic                 done,
  output logic [dataWidth-1:0] result
);

  logic [profileCounterCount-1:0][dataWidth-1:0] s_counterReg;
  logic [profileCounterCount-1:0]                s_enableReg;
  logic [profileCounterCount-1:0]                s_countEvent;
  logic [profileCounterCount-1:0]                s_setMask;
  logic [profileCounterCount-1:0]                s_clearMask;
  logic [profileCounterCount-1:0]                s_zeroMask;
  logic [1:0]                                    s_select;
  logic                                          s_isProfile;

  assign s_isProfile = ci.ciStart && (ci.ciN == profileId);

  // Command fields only act on a profile start
  assign s_setMask   = s_isProfile ?
                       ci.ciDataB[profileEnableLsb +: profileCounterCount] : '0;
  assign s_clearMask = s_isProfile ?
                       ci.ciDataB[profileDisableLsb +: profileCounterCount] : '0;
  assign s_zeroMask  = s_isProfile ?
                       ci.ciDataB[profileZeroLsb +: profileCounterCount] : '0;

  // Cycles, stall cycles, bus idle cycles
  assign s_countEvent = {busIdle, cpuStalled, 1'b1};

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      s_counterReg <= '0;
      s_enableReg  <= '0;
    end else begin
      s_enableReg <= (s_enableReg | s_setMask) & ~s_clearMask; // Clear beats set
      for (int i = 0; i < profileCounterCount; i++) begin
        if (s_zeroMask[i]) begin
          s_counterReg[i] <= '0; // Zeroing wins over counting
        end else if (s_enableReg[i] && s_countEvent[i]) begin
          s_counterReg[i] <= s_counterReg[i] + 1'b1;
        end
      end
    end
  end

  assign s_select = ci.ciDataA[1:0];

  // Value before this cycle's update
  always_comb begin
    result = '0;
    if (s_isProfile && (s_select < profileCounterCount)) begin
      result = s_counterReg[s_select];
    end
  end

  assign done = s_isProfile;

endmodule

//--- hw/ciSubsystem.sv
`timescale 1ns/1ps

module ciSubsystem import ciPkg::*; (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  input  logic                     ciStart,
  input  logic [ciNumberWidth-1:0] ciN,
  input  logic [dataWidth-1:0]     ciDataA,
  input  logic [dataWidth-1:0]     ciDataB,
  input  logic                     cpuStalled,
  input  logic                     busIdle,
  output logic                     ciDone,
  output logic [dataWidth-1:0]     ciResult,
  output logic                     peripheralResetN
);

  logic                 s_reset;
  logic                 s_delayDone;
  logic                 s_conversionDone;
  logic                 s_profileDone;
  logic [dataWidth-1:0] s_delayResult;
  logic [dataWidth-1:0] s_conversionResult;
  logic [dataWidth-1:0] s_profileResult;

  ciBus ciRequest ();

  // Request side of the instruction port
  assign ciRequest.ciStart = ciStart;
  assign ciRequest.ciN     = ciN;
  assign ciRequest.ciDataA = ciDataA;
  assign ciRequest.ciDataB = ciDataB;

  resetSequencer sequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .reset(s_reset),
    .peripheralResetN(peripheralResetN)
  );

  // Instruction 6
  delayController delayMicro (
    .s_systemClock(s_systemClock),
    .reset(s_reset),
    .ci(ciRequest),
    .done(s_delayDone),
    .result(s_delayResult)
  );

  // Instructions 1 and 12
  dataConversionUnit conversion (
    .ci(ciRequest),
    .done(s_conversionDone),
    .result(s_conversionResult)
  );

  // Instruction 8
  profileCounters profile (
    .s_systemClock(s_systemClock),
    .reset(s_reset),
    .cpuStalled(cpuStalled),
    .busIdle(busIdle),
    .ci(ciRequest),
    .done(s_profileDone),
    .result(s_profileResult)
  );

  // Idle units drive zero, so a plain OR combines them
  assign ciDone   = s_delayDone | s_conversionDone | s_profileDone;
  assign ciResult = s_delayResult | s_conversionResult | s_profileResult;

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic s_systemClock,
  output logic s_pllLocked
);

  localparam int periodNs    = 100;
  localparam int resetCycles = 2;

  initial begin
    s_systemClock = 1'b0;
    forever #(periodNs / 2) s_systemClock = ~s_systemClock;
  end

  // Lock arrives on a falling edge
  initial begin
    s_pllLocked = 1'b0;
    #(resetCycles * periodNs);
    s_pllLocked = 1'b1;
  end

endmodule

//--- testbench/ciModel.svh
`ifndef CI_MODEL_SVH
`define CI_MODEL_SVH

// Profiling state stepped on every rising edge
logic [dataWidth-1:0]           modelCounter [profileCounterCount] = '{default: '0};
logic [profileCounterCount-1:0] modelEnable = '0;

function automatic logic [dataWidth-1:0] swapModel(input ciOperand operand);
  return {operand.bytes[0], operand.bytes[1], operand.bytes[2], operand.bytes[3]};
endfunction

// Weighted luma of the widened RGB565 pixel
function automatic logic [dataWidth-1:0] grayscaleModel(input ciOperand operand);
  int red;
  int green;
  int blue;
  red   = operand.pixel.red * 8;
  green = operand.pixel.green * 4;
  blue  = operand.pixel.blue * 8;
  return (54 * red + 183 * green + 19 * blue) / 256;
endfunction

function automatic void profileModelStep(input logic isProfile, input logic [31:0] command,
                                         input logic stalled, input logic busWasIdle);
  logic [2:0] events;
  logic [2:0] setMask;
  logic [2:0] clearMask;
  logic [2:0] zeroMask;
  events    = {busWasIdle, stalled, 1'b1};
  setMask   = isProfile ? command[2:0] : 3'b000;
  clearMask = isProfile ? command[6:4] : 3'b000;
  zeroMask  = isProfile ? command[10:8] : 3'b000;
  for (int i = 0; i < profileCounterCount; i++) begin
    if (zeroMask[i]) begin
      modelCounter[i] = '0;
    end else if (modelEnable[i] && events[i]) begin
      modelCounter[i] = modelCounter[i] + 1;
    end
  end
  modelEnable = (modelEnable | setMask) & ~clearMask; // Disable wins
endfunction

function automatic logic [dataWidth-1:0] profileModelRead(input logic [1:0] select);
  if (select < profileCounterCount) begin
    return modelCounter[select];
  end
  return '0;
endfunction

`endif

//--- testbench/ciSubsystemTb.sv
`timescale 1ns/1ps

module ciSubsystemTb import ciPkg::*; ();

  localparam int clockPeriodNs   = 100;
  localparam int settleNs        = 10;
  localparam int conversionCount = 200;
  localparam int unknownCount    = 20;
  localparam int profileOpCount  = 300;
  localparam int delayCount      = 40;
  localparam int mixedRounds     = 12;
  localparam int delayWaitLimit  = 15 * ticksPerMicrosecond + 20;
  // Cycle budget summed over all tests
  localparam int watchdogCycles  = 40 + (2 * conversionCount + unknownCount) * 2 +
                                   profileOpCount * 3 + delayCount * (delayWaitLimit + 3) +
                                   mixedRounds * (delayWaitLimit + 10) + 500;

  logic                     s_systemClock;
  logic                     s_pllLocked;
  logic                     ciStart;
  logic [ciNumberWidth-1:0] ciN;
  logic [dataWidth-1:0]     ciDataA;
  logic [dataWidth-1:0]     ciDataB;
  logic                     cpuStalled;
  logic                     busIdle;
  logic                     ciDone;
  logic [dataWidth-1:0]     ciResult;
  logic                     peripheralResetN;

  logic [31:0] lfsrState   = 32'habe;
  int          cycleCount  = 0;
  int          checkCount  = 0;
  int          errorCount  = 0;
  int          testChecks  = 0;
  int          testErrors  = 0;
  int          testsRun    = 0;
  string       currentTest = "startup";

  `include "ciModel.svh"

  tbClock clockGen (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked)
  );

  ciSubsystem UUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .cpuStalled(cpuStalled),
    .busIdle(busIdle),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .peripheralResetN(peripheralResetN)
  );

  always @(posedge s_systemClock) begin
    cycleCount++;
    profileModelStep(ciStart && (ciN == profileId), ciDataB, cpuStalled, busIdle);
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], feedback};
      value     = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    testChecks++;
    if (actual !== expected) begin
      $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic beginTest(input string name);
    currentTest = name;
    testChecks  = 0;
    testErrors  = 0;
  endtask

  task automatic endTest();
    testsRun++;
    $display("Test %s finished: %0d checks, %0d errors", currentTest, testChecks, testErrors);
  endtask

  task automatic idleCycle();
    @(negedge s_systemClock);
    ciStart    = 1'b0;
    cpuStalled = randomBits(1);
    busIdle    = randomBits(1);
  endtask

  // Drive a start and let the combinational answer settle
  task automatic startInstruction(input logic [7:0] number, input logic [31:0] operandA,
                                  input logic [31:0] operandB);
    @(negedge s_systemClock);
    ciStart    = 1'b1;
    ciN        = number;
    ciDataA    = operandA;
    ciDataB    = operandB;
    cpuStalled = randomBits(1);
    busIdle    = randomBits(1);
    #(settleNs);
  endtask

  task automatic checkSwap(input ciOperand operand);
    startInstruction(swapId, operand, randomBits(32));
    checkValue("ciDone", 1, ciDone);
    checkValue("ciResult", swapModel(operand), ciResult);
    idleCycle();
  endtask

  task automatic checkGray(input ciOperand operand);
    startInstruction(grayscaleId, operand, randomBits(32));
    checkValue("ciDone", 1, ciDone);
    checkValue("ciResult", grayscaleModel(operand), ciResult);
    idleCycle();
  endtask

  task automatic checkProfileRead(input logic [1:0] select, input logic [31:0] command,
                                  output logic [31:0] value, output int cycle);
    startInstruction(profileId, 32'(select), command);
    value = ciResult;
    cycle = cycleCount;
    checkValue("ciDone", 1, ciDone);
    checkValue("ciResult", profileModelRead(select), ciResult);
    idleCycle();
  endtask

  task automatic runDelay(input logic [31:0] micros);
    int   cycles;
    int   expectedCycles;
    logic seen;
    expectedCycles = (micros == 0) ? 1 : micros * 10 + 1; // 10 cycles per microsecond
    cycles         = 0;
    seen           = 1'b0;
    startInstruction(delayId, micros, randomBits(32));
    checkValue("ciDone", 0, ciDone);
    while (!seen && cycles < delayWaitLimit) begin
      idleCycle();
      #(settleNs);
      cycles++;
      seen = ciDone;
    end
    if (!seen) begin
      $display("Delay of %0d us never raised done within %0d cycles", micros, cycles);
      errorCount++;
      testErrors++;
    end else begin
      checkValue("delay cycles", expectedCycles, cycles);
      checkValue("ciResult", 0, ciResult);
      idleCycle();
      #(settleNs);
      checkValue("ciDone", 0, ciDone); // Single cycle pulse
    end
  endtask

  task automatic resetTest();
    int edges;
    edges = 0;
    beginTest("reset");
    // Zero length delay starts that the held delay unit must ignore
    ciN     = delayId;
    ciDataA = '0;
    do begin
      @(negedge s_systemClock);
      ciStart = 1'b1;
      #(settleNs);
      if (!s_pllLocked) begin
        checkValue("peripheralResetN", 0, peripheralResetN);
        checkValue("ciDone", 0, ciDone);
      end
    end while (!s_pllLocked);
    while (!peripheralResetN && edges < 40) begin
      @(negedge s_systemClock);
      ciStart = !peripheralResetN; // Stop requesting once released
      #(settleNs);
      edges++;
      checkValue("ciDone", 0, ciDone);
    end
    checkValue("reset release edges", 16, edges);
    endTest();
  endtask

  task automatic conversionTest();
    logic [7:0] number;
    beginTest("conversion");
    for (int i = 0; i < conversionCount; i++) begin
      checkSwap(randomBits(32));
    end
    for (int i = 0; i < conversionCount; i++) begin
      checkGray(randomBits(32));
    end
    for (int i = 0; i < unknownCount; i++) begin
      do begin
        number = randomBits(8);
      end while (number == swapId || number == delayId || number == profileId ||
                 number == grayscaleId);
      startInstruction(number, randomBits(32), randomBits(32));
      checkValue("ciDone", 0, ciDone);
      checkValue("ciResult", 0, ciResult);
      idleCycle();
    end
    endTest();
  endtask

  task automatic profileTest();
    logic [31:0] command;
    logic [31:0] value;
    int          cycle;
    beginTest("profile");
    for (int i = 0; i < profileOpCount; i++) begin
      if (randomBits(2) == 0) begin
        idleCycle();
      end
      command        = '0;
      command[2:0]   = randomBits(3);
      command[6:4]   = randomBits(3) & randomBits(3);
      command[10:8]  = (randomBits(3) == 0) ? randomBits(3) : 3'b000;
      checkProfileRead(randomBits(2), command, value, cycle);
    end
    endTest();
  endtask

  task automatic delayTest();
    beginTest("delay");
    runDelay(0);
    for (int i = 1; i < delayCount; i++) begin
      runDelay(randomBits(4));
    end
    endTest();
  endtask

  task automatic mixedTest();
    logic [31:0] startValue;
    logic [31:0] endValue;
    logic [31:0] value;
    int          startCycle;
    int          endCycle;
    int          cycle;
    beginTest("mixed");
    checkProfileRead(0, 32'h1, value, cycle); // Enable the cycle counter
    checkProfileRead(0, 32'h0, startValue, startCycle);
    for (int round = 0; round < mixedRounds; round++) begin
      runDelay(randomBits(4));
      repeat (3) begin
        case (randomBits(2))
          2'd0:    checkSwap(randomBits(32));
          2'd1:    checkGray(randomBits(32));
          default: checkProfileRead(randomBits(2), randomBits(3), value, cycle);
        endcase
      end
    end
    checkProfileRead(0, 32'h0, endValue, endCycle);
    checkValue("cycle counter advance", endCycle - startCycle, endValue - startValue);
    endTest();
  endtask

  initial begin
    ciStart    = 1'b0;
    ciN        = '0;
    ciDataA    = '0;
    ciDataB    = '0;
    cpuStalled = 1'b0;
    busIdle    = 1'b0;
    resetTest();
    conversionTest();
    profileTest();
    delayTest();
    mixedTest();
    $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(watchdogCycles * clockPeriodNs);
    $display("Watchdog expired after %0d cycles, test %s hung", watchdogCycles, currentTest);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+testbench
hw/ciPkg.sv
hw/ciBus.sv
hw/resetSequencer.sv
hw/microsecondTimer.sv
hw/delayController.sv
hw/dataConversionUnit.sv
hw/profileCounters.sv
hw/ciSubsystem.sv
testbench/tbClock.sv
testbench/ciSubsystemTb.sv

//--- Bender.yml
package:
  name: ci_subsystem

sources:
  - hw/ciPkg.sv
  - hw/ciBus.sv
  - hw/resetSequencer.sv
  - hw/microsecondTimer.sv
  - hw/delayController.sv
  - hw/dataConversionUnit.sv
  - hw/profileCounters.sv
  - hw/ciSubsystem.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tbClock.sv
      - testbench/ciSubsystemTb.sv
